/* hdl/sdr_ctrl_cfg.svh */
`ifndef SDR_CTRL_CFG_SVH
`define SDR_CTRL_CFG_SVH

// CAS latency, also written into the mode register
`define SDR_CL            3'd2

// Wait counts in clock cycles
`define SDR_T_RCD         4'd3
`define SDR_T_RP          4'd3
`define SDR_T_RFC         4'd7
`define SDR_INIT_WAIT     16'd200
`define SDR_REF_INTERVAL  12'd390

// SDRAM address fields
`define SDR_ROW_W         13
`define SDR_COL_W         9
`define SDR_BA_W          2

`define SDR_DQ_W          16
`define SDR_WB_DAT_W      32
`define SDR_DQM_W         (`SDR_DQ_W / 8)
`define SDR_WB_SEL_W      (`SDR_WB_DAT_W / 8)

// Word address is bank, row, column pair
`define SDR_WB_ADR_W      (`SDR_BA_W + `SDR_ROW_W + `SDR_COL_W - 1)

`endif

/* hdl/sdr_ctrl_pkg.sv */
package sdr_ctrl_pkg;

   // Pin order is cs_n, ras, cas, we
   typedef enum logic [3:0] {
      LOAD_MODE = 4'b0000,
      REFRESH   = 4'b0001,
      PRECHARGE = 4'b0010,
      ACTIVE    = 4'b0011,
      WRITE     = 4'b0100,
      READ      = 4'b0101,
      NOP       = 4'b0111,
      INHIBIT   = 4'b1111
   } sdr_cmd_e;

   typedef enum logic [3:0] {
      ST_INIT_WAIT,
      ST_INIT_REF1,
      ST_INIT_REF2,
      ST_INIT_LMR,
      ST_IDLE,
      ST_ACT,
      ST_OPEN,
      ST_WR_LO,
      ST_RD_WAIT
   } sdr_state_e;

   typedef enum logic [2:0] {
      CLASSIC = 3'b000,
      INCR    = 3'b010,
      END     = 3'b111
   } wb_cti_e;

   typedef enum logic [1:0] {
      LINEAR = 2'b00,
      WRAP4  = 2'b01
   } wb_bte_e;

endpackage

/* hdl/sdr_req_if.sv */
`include "sdr_ctrl_cfg.svh"

interface sdr_req_if;
   logic                      req;
   logic                      we;
   logic [`SDR_WB_ADR_W-1:0]  adr;
   logic [`SDR_WB_DAT_W-1:0]  wdat;
   logic [`SDR_WB_SEL_W-1:0]  sel;
   sdr_ctrl_pkg::wb_cti_e     cti;
   sdr_ctrl_pkg::wb_bte_e     bte;
   logic                      beat_done;
   logic                      rdat_vld;

   modport master (
      output req, we, adr, wdat, sel, cti, bte,
      input  beat_done, rdat_vld
   );

   modport slave (
      input  req, we, adr, wdat, sel, cti, bte,
      output beat_done, rdat_vld
   );

   // Burst address generator only looks
   modport burst (
      input adr, cti, bte
   );
endinterface

/* hdl/sdr_wb_port.sv */
`include "sdr_ctrl_cfg.svh"

module sdr_wb_port (
   input  logic                      sdram_clk_0,
   input  logic                      wb_rst,
   input  logic [`SDR_WB_ADR_W-1:0]  wb_adr_i,
   input  logic [`SDR_WB_DAT_W-1:0]  wb_dat_i,
   input  logic [`SDR_WB_SEL_W-1:0]  wb_sel_i,
   input  logic                      wb_we_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_cyc_i,
   input  logic [2:0]                wb_cti_i,
   input  logic [1:0]                wb_bte_i,
   output logic [`SDR_WB_DAT_W-1:0]  wb_dat_o,
   output logic                      wb_ack_o,
   sdr_req_if.master                 req,
   input  logic [`SDR_WB_DAT_W-1:0]  rdat_i,
   input  logic                      rdat_vld_i
);

   logic wb_active;

   assign wb_active = wb_cyc_i && wb_stb_i;

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         req.req  <= 1'b0;
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= req.beat_done && wb_active;
         if (req.beat_done || !wb_active) begin
            req.req <= 1'b0;
         // Skip the acked beat still on the bus
         end else if (!req.req && !wb_ack_o) begin
            req.req <= 1'b1;
         end
      end
   end

   // Fields follow the bus until the request is raised
   always_ff @(posedge sdram_clk_0) begin
      if (!req.req) begin
         req.we   <= wb_we_i;
         req.adr  <= wb_adr_i;
         req.wdat <= wb_dat_i;
         req.sel  <= wb_sel_i;
         req.cti  <= sdr_ctrl_pkg::wb_cti_e'(wb_cti_i);
         req.bte  <= sdr_ctrl_pkg::wb_bte_e'(wb_bte_i);
      end
      if (rdat_vld_i && req.rdat_vld) begin
         wb_dat_o <= rdat_i;
      end
   end

endmodule

/* hdl/sdr_burst_adr.sv */
`include "sdr_ctrl_cfg.svh"

module sdr_burst_adr (
   input  logic                    sdram_clk_0,
   input  logic                    wb_rst,
   sdr_req_if.burst                req,
   input  logic                    init_i,
   input  logic                    inc_i,
   output logic [`SDR_COL_W-2:0]   burst_col_o,
   output logic                    done_o
);

   logic [1:0] beat_cnt;

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         burst_col_o <= '0;
         beat_cnt    <= 2'd0;
      end else if (init_i) begin
         burst_col_o <= req.adr[`SDR_COL_W-2:0];
         beat_cnt    <= 2'd0;
      end else if (inc_i) begin
         beat_cnt <= beat_cnt + 2'd1;
         if (req.bte == sdr_ctrl_pkg::WRAP4) begin
            // Upper bits stay, low pair wraps
            burst_col_o[1:0] <= burst_col_o[1:0] + 2'd1;
         end else begin
            burst_col_o <= burst_col_o + 1'b1;
         end
      end
   end

   assign done_o = (req.cti == sdr_ctrl_pkg::CLASSIC) ||
                   (req.cti == sdr_ctrl_pkg::END) ||
                   (req.bte == sdr_ctrl_pkg::WRAP4 && beat_cnt == 2'd3);

endmodule

/* hdl/sdr_cmd_fsm.sv */
`include "sdr_ctrl_cfg.svh"

module sdr_cmd_fsm (
   input  logic                    sdram_clk_0,
   input  logic                    wb_rst,
   sdr_req_if.slave                req,
   input  logic [`SDR_COL_W-2:0]   burst_col_i,
   input  logic                    done_i,
   output logic                    adr_init_o,
   output logic                    adr_inc_o,
   output logic                    dq_hi_o,
   output logic                    dq_lo_o,
   output logic                    read_strobe_o,
   output sdr_ctrl_pkg::sdr_cmd_e  cmd_o,
   output logic [`SDR_BA_W-1:0]    ba_o,
   output logic [`SDR_ROW_W-1:0]   a_o,
   output logic [`SDR_DQM_W-1:0]   dqm_o
);

   // A10 set selects all banks
   localparam logic [`SDR_ROW_W-1:0] A_PRE_ALL = {{(`SDR_ROW_W-11){1'b0}}, 1'b1, 10'd0};
   // Burst length 2, sequential, CAS latency
   localparam logic [`SDR_ROW_W-1:0] MODE_WORD = {{(`SDR_ROW_W-7){1'b0}}, `SDR_CL, 1'b0, 3'b001};

   sdr_ctrl_pkg::sdr_state_e state;
   logic [15:0] wait_cnt;
   logic [11:0] ref_cnt;
   logic        ref_pend;
   logic        ref_issue;
   logic        last_q;
   logic        wait_done;
   logic        new_beat;
   logic        start;
   logic        issue;

   assign wait_done = wait_cnt == 16'd0;
   // Request still high in the done cycle belongs to the old beat
   assign new_beat  = req.req && !req.beat_done;
   assign ref_issue = state == sdr_ctrl_pkg::ST_IDLE && wait_done && ref_pend;
   assign start     = state == sdr_ctrl_pkg::ST_IDLE && wait_done && !ref_pend && new_beat;
   assign issue     = (state == sdr_ctrl_pkg::ST_ACT && wait_done) ||
                      (state == sdr_ctrl_pkg::ST_OPEN && wait_done && !ref_pend && new_beat);

   assign adr_init_o = start && last_q;
   assign adr_inc_o  = issue;
   // One cycle early so the high half meets WRITE
   assign dq_hi_o    = issue && req.we;
   assign dq_lo_o    = state == sdr_ctrl_pkg::ST_WR_LO;

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         ref_cnt  <= `SDR_REF_INTERVAL;
         ref_pend <= 1'b0;
      end else begin
         if (ref_issue) begin
            ref_pend <= 1'b0;
         end
         if (ref_cnt == 12'd0) begin
            ref_cnt  <= `SDR_REF_INTERVAL;
            ref_pend <= 1'b1;
         end else begin
            ref_cnt <= ref_cnt - 12'd1;
         end
      end
   end

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         state         <= sdr_ctrl_pkg::ST_INIT_WAIT;
         wait_cnt      <= `SDR_INIT_WAIT;
         last_q        <= 1'b1;
         cmd_o         <= sdr_ctrl_pkg::INHIBIT;
         ba_o          <= '0;
         a_o           <= '0;
         dqm_o         <= '0;
         read_strobe_o <= 1'b0;
         req.beat_done <= 1'b0;
         req.rdat_vld  <= 1'b0;
      end else begin
         cmd_o         <= sdr_ctrl_pkg::NOP;
         dqm_o         <= '0;
         read_strobe_o <= 1'b0;
         req.beat_done <= 1'b0;
         req.rdat_vld  <= 1'b0;
         if (!wait_done) begin
            wait_cnt <= wait_cnt - 16'd1;
         end
         case (state)
            sdr_ctrl_pkg::ST_INIT_WAIT: begin
               cmd_o <= sdr_ctrl_pkg::INHIBIT;
               if (wait_done) begin
                  cmd_o    <= sdr_ctrl_pkg::PRECHARGE;
                  a_o      <= A_PRE_ALL;
                  wait_cnt <= 16'(`SDR_T_RP - 1);
                  state    <= sdr_ctrl_pkg::ST_INIT_REF1;
               end
            end
            sdr_ctrl_pkg::ST_INIT_REF1: begin
               if (wait_done) begin
                  cmd_o    <= sdr_ctrl_pkg::REFRESH;
                  wait_cnt <= 16'(`SDR_T_RFC - 1);
                  state    <= sdr_ctrl_pkg::ST_INIT_REF2;
               end
            end
            sdr_ctrl_pkg::ST_INIT_REF2: begin
               if (wait_done) begin
                  cmd_o    <= sdr_ctrl_pkg::REFRESH;
                  wait_cnt <= 16'(`SDR_T_RFC - 1);
                  state    <= sdr_ctrl_pkg::ST_INIT_LMR;
               end
            end
            sdr_ctrl_pkg::ST_INIT_LMR: begin
               if (wait_done) begin
                  cmd_o    <= sdr_ctrl_pkg::LOAD_MODE;
                  ba_o     <= '0;
                  a_o      <= MODE_WORD;
                  wait_cnt <= 16'd1;
                  state    <= sdr_ctrl_pkg::ST_IDLE;
               end
            end
            sdr_ctrl_pkg::ST_IDLE: begin
               if (ref_issue) begin
                  cmd_o    <= sdr_ctrl_pkg::REFRESH;
                  wait_cnt <= 16'(`SDR_T_RFC - 1);
               end else if (start) begin
                  cmd_o    <= sdr_ctrl_pkg::ACTIVE;
                  ba_o     <= req.adr[`SDR_WB_ADR_W-1 -: `SDR_BA_W];
                  a_o      <= req.adr[`SDR_COL_W-1 +: `SDR_ROW_W];
                  wait_cnt <= 16'(`SDR_T_RCD - 1);
                  state    <= sdr_ctrl_pkg::ST_ACT;
               end
            end
            sdr_ctrl_pkg::ST_OPEN: begin
               // Row must close before a refresh
               if (wait_done && ref_pend) begin
                  cmd_o    <= sdr_ctrl_pkg::PRECHARGE;
                  a_o      <= A_PRE_ALL;
                  wait_cnt <= 16'(`SDR_T_RP - 1);
                  state    <= sdr_ctrl_pkg::ST_IDLE;
               end
            end
            sdr_ctrl_pkg::ST_WR_LO: begin
               dqm_o         <= ~req.sel[1:0];
               req.beat_done <= 1'b1;
               if (last_q) begin
                  // Write recovery, then auto-precharge
                  wait_cnt <= 16'(`SDR_T_RP + 1);
                  state    <= sdr_ctrl_pkg::ST_IDLE;
               end else begin
                  wait_cnt <= 16'd1;
                  state    <= sdr_ctrl_pkg::ST_OPEN;
               end
            end
            sdr_ctrl_pkg::ST_RD_WAIT: begin
               if (wait_done) begin
                  req.beat_done <= 1'b1;
                  req.rdat_vld  <= 1'b1;
                  if (last_q) begin
                     wait_cnt <= 16'(`SDR_T_RP - 1);
                     state    <= sdr_ctrl_pkg::ST_IDLE;
                  end else begin
                     state <= sdr_ctrl_pkg::ST_OPEN;
                  end
               end
            end
            default: begin
            end
         endcase
         if (issue) begin
            // Half 0 of the column pair, A10 on the last beat
            a_o    <= {{(`SDR_ROW_W-11){1'b0}}, done_i, {(10-`SDR_COL_W){1'b0}},
                       burst_col_i, 1'b0};
            last_q <= done_i;
            if (req.we) begin
               cmd_o <= sdr_ctrl_pkg::WRITE;
               dqm_o <= ~req.sel[3:2];
               state <= sdr_ctrl_pkg::ST_WR_LO;
            end else begin
               cmd_o         <= sdr_ctrl_pkg::READ;
               read_strobe_o <= 1'b1;
               wait_cnt      <= 16'(`SDR_CL + 1);
               state         <= sdr_ctrl_pkg::ST_RD_WAIT;
            end
         end
      end
   end

endmodule

/* hdl/sdr_dq_path.sv */
`include "sdr_ctrl_cfg.svh"

module sdr_dq_path (
   input  logic                      sdram_clk_0,
   input  logic                      wb_rst,
   input  logic [`SDR_WB_DAT_W-1:0]  wdat_i,
   input  logic                      dq_hi_i,
   input  logic                      dq_lo_i,
   input  logic                      read_strobe_i,
   input  logic [`SDR_DQ_W-1:0]      dq_i,
   output logic [`SDR_DQ_W-1:0]      dq_o,
   output logic                      dq_oe_o,
   output logic [`SDR_WB_DAT_W-1:0]  rdat_o,
   output logic                      rdat_vld_o
);

   localparam int RD_LAT = `SDR_CL + 2;

   logic [`SDR_DQ_W-1:0] dq_in_q;
   logic [`SDR_DQ_W-1:0] dq_in_hi_q;
   logic [RD_LAT-1:0]    rd_pipe;

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         dq_o    <= '0;
         dq_oe_o <= 1'b0;
         rd_pipe <= '0;
      end else begin
         dq_oe_o <= dq_hi_i | dq_lo_i;
         if (dq_hi_i) begin
            dq_o <= wdat_i[`SDR_WB_DAT_W-1 -: `SDR_DQ_W];
         end else if (dq_lo_i) begin
            dq_o <= wdat_i[`SDR_DQ_W-1:0];
         end else begin
            dq_o <= '0;
         end
         // Strobes may overlap in flight
         rd_pipe <= {rd_pipe[RD_LAT-2:0], read_strobe_i};
      end
   end

   // High half arrives first
   always_ff @(posedge sdram_clk_0) begin
      dq_in_q    <= dq_i;
      dq_in_hi_q <= dq_in_q;
   end

   assign rdat_o     = {dq_in_hi_q, dq_in_q};
   assign rdat_vld_o = rd_pipe[RD_LAT-1];

endmodule

/* hdl/sdr_ctrl_top.sv */
`include "sdr_ctrl_cfg.svh"

module sdr_ctrl_top (
   input  logic                      sdram_clk_0,
   input  logic                      wb_rst,
   input  logic [`SDR_WB_ADR_W-1:0]  wb_adr_i,
   input  logic [`SDR_WB_DAT_W-1:0]  wb_dat_i,
   input  logic [`SDR_WB_SEL_W-1:0]  wb_sel_i,
   input  logic                      wb_we_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_cyc_i,
   input  logic [2:0]                wb_cti_i,
   input  logic [1:0]                wb_bte_i,
   output logic [`SDR_WB_DAT_W-1:0]  wb_dat_o,
   output logic                      wb_ack_o,
   output logic [`SDR_BA_W-1:0]      ba_o,
   output logic [`SDR_ROW_W-1:0]     a_o,
   output logic                      cs_n_o,
   output logic                      ras_o,
   output logic                      cas_o,
   output logic                      we_o,
   output logic [`SDR_DQM_W-1:0]     dqm_o,
   output logic [`SDR_DQ_W-1:0]      dq_o,
   output logic                      dq_oe_o,
   output logic                      cke_o,
   input  logic [`SDR_DQ_W-1:0]      dq_i
);

   sdr_ctrl_pkg::sdr_cmd_e        cmd;
   logic [`SDR_COL_W-2:0]         burst_col;
   logic                          done;
   logic                          adr_init;
   logic                          adr_inc;
   logic                          dq_hi;
   logic                          dq_lo;
   logic                          read_strobe;
   logic [`SDR_WB_DAT_W-1:0]      rdat;
   logic                          rdat_vld;

   sdr_req_if req_bus ();

   assign {cs_n_o, ras_o, cas_o, we_o} = cmd;
   assign cke_o = 1'b1;

   sdr_wb_port sdr_wb_port_inst (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_we_i     (wb_we_i),
      .wb_stb_i    (wb_stb_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_cti_i    (wb_cti_i),
      .wb_bte_i    (wb_bte_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .req         (req_bus.master),
      .rdat_i      (rdat),
      .rdat_vld_i  (rdat_vld)
   );

   sdr_burst_adr sdr_burst_adr_inst (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .req         (req_bus.burst),
      .init_i      (adr_init),
      .inc_i       (adr_inc),
      .burst_col_o (burst_col),
      .done_o      (done)
   );

   sdr_cmd_fsm sdr_cmd_fsm_inst (
      .sdram_clk_0   (sdram_clk_0),
      .wb_rst        (wb_rst),
      .req           (req_bus.slave),
      .burst_col_i   (burst_col),
      .done_i        (done),
      .adr_init_o    (adr_init),
      .adr_inc_o     (adr_inc),
      .dq_hi_o       (dq_hi),
      .dq_lo_o       (dq_lo),
      .read_strobe_o (read_strobe),
      .cmd_o         (cmd),
      .ba_o          (ba_o),
      .a_o           (a_o),
      .dqm_o         (dqm_o)
   );

   sdr_dq_path sdr_dq_path_inst (
      .sdram_clk_0   (sdram_clk_0),
      .wb_rst        (wb_rst),
      .wdat_i        (req_bus.wdat),
      .dq_hi_i       (dq_hi),
      .dq_lo_i       (dq_lo),
      .read_strobe_i (read_strobe),
      .dq_i          (dq_i),
      .dq_o          (dq_o),
      .dq_oe_o       (dq_oe_o),
      .rdat_o        (rdat),
      .rdat_vld_o    (rdat_vld)
   );

endmodule

/* verif/sdr_ctrl_sva.sv */
`include "sdr_ctrl_cfg.svh"

module sdr_ctrl_sva (
   input logic sdram_clk_0,
   input logic wb_rst,
   input logic wb_ack_o,
   input logic wb_cyc_i,
   input logic dq_oe_o,
   input logic cs_n_o,
   input logic ras_o,
   input logic cas_o,
   input logic we_o
);
   timeunit 1ns;
   timeprecision 100ps;

   // Longest beat that can hold off a pending refresh
   localparam int REF_BOUND = int'(`SDR_REF_INTERVAL) + 64;

   logic [3:0]  cmd;
   logic [15:0] since_act;
   logic [15:0] since_ref;
   int          fail_cnt = 0;

   assign cmd = {cs_n_o, ras_o, cas_o, we_o};

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         since_act <= 16'hffff;
         since_ref <= 16'd0;
      end else begin
         if (cmd == sdr_ctrl_pkg::ACTIVE) begin
            since_act <= 16'd1;
         end else if (since_act != 16'hffff) begin
            since_act <= since_act + 16'd1;
         end
         if (cmd == sdr_ctrl_pkg::REFRESH) begin
            since_ref <= 16'd0;
         end else if (since_ref != 16'hffff) begin
            since_ref <= since_ref + 16'd1;
         end
      end
   end

   ack_single: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      wb_ack_o |=> !wb_ack_o)
      else begin
         fail_cnt++;
         $error("wb_ack_o high for two cycles");
      end

   ack_in_cycle: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      wb_ack_o |-> wb_cyc_i)
      else begin
         fail_cnt++;
         $error("wb_ack_o high without wb_cyc_i");
      end

   oe_in_write: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      dq_oe_o |-> (cmd == sdr_ctrl_pkg::WRITE || $past(cmd) == sdr_ctrl_pkg::WRITE))
      else begin
         fail_cnt++;
         $error("dq_oe_o high outside a write");
      end

   rcd_met: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      (cmd == sdr_ctrl_pkg::READ || cmd == sdr_ctrl_pkg::WRITE) |->
         since_act >= 16'(`SDR_T_RCD))
      else begin
         fail_cnt++;
         $error("column command too soon after ACTIVE");
      end

   ref_recurs: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      since_ref <= 16'(REF_BOUND))
      else begin
         fail_cnt++;
         $error("refresh overdue");
      end

endmodule

bind sdr_ctrl_top sdr_ctrl_sva sdr_ctrl_sva_inst (
   .sdram_clk_0 (sdram_clk_0),
   .wb_rst      (wb_rst),
   .wb_ack_o    (wb_ack_o),
   .wb_cyc_i    (wb_cyc_i),
   .dq_oe_o     (dq_oe_o),
   .cs_n_o      (cs_n_o),
   .ras_o       (ras_o),
   .cas_o       (cas_o),
   .we_o        (we_o)
);

/* verif/sdr_ctrl_tb.sv */
`include "sdr_ctrl_cfg.svh"

module sdr_ctrl_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int BEAT_WORST = int'(`SDR_T_RP) + int'(`SDR_T_RFC) + int'(`SDR_T_RCD) +
                               int'(`SDR_CL) + 20;
   localparam int N_BEATS    = 70;
   localparam int GAP_CYCLES = 4 * int'(`SDR_REF_INTERVAL) + 20;
   localparam int WD_CYCLES  = 2 * (int'(`SDR_INIT_WAIT) + 100 + N_BEATS * (BEAT_WORST + 3) +
                               GAP_CYCLES);

   logic                      sdram_clk_0 = 1'b0;
   logic                      wb_rst;
   logic [`SDR_WB_ADR_W-1:0]  wb_adr_i;
   logic [`SDR_WB_DAT_W-1:0]  wb_dat_i;
   logic [`SDR_WB_SEL_W-1:0]  wb_sel_i;
   logic                      wb_we_i;
   logic                      wb_stb_i;
   logic                      wb_cyc_i;
   logic [2:0]                wb_cti_i;
   logic [1:0]                wb_bte_i;
   logic [`SDR_WB_DAT_W-1:0]  wb_dat_o;
   logic                      wb_ack_o;
   logic [`SDR_BA_W-1:0]      ba_o;
   logic [`SDR_ROW_W-1:0]     a_o;
   logic                      cs_n_o;
   logic                      ras_o;
   logic                      cas_o;
   logic                      we_o;
   logic [`SDR_DQM_W-1:0]     dqm_o;
   logic [`SDR_DQ_W-1:0]      dq_o;
   logic                      dq_oe_o;
   logic                      cke_o;
   logic [`SDR_DQ_W-1:0]      dq_i = '0;

   logic [31:0]  lfsr = 32'h9922_5774;
   logic [15:0]  sdram_mem [int];
   logic [31:0]  exp_mem [int];
   logic [12:0]  open_row [4];
   logic [3:0]   bank_open = 4'b0;
   logic [15:0]  rd_pipe [4];
   logic         wr_lo_pend = 1'b0;
   int           wr_key;
   logic [3:0]   init_cmd [4];
   logic [12:0]  init_a [4];
   int           init_n = 0;
   int           errors = 0;
   int           bad_tests = 0;

   always #10 sdram_clk_0 = ~sdram_clk_0;

   sdr_ctrl_top sdr_ctrl_top_inst (.*);

   // Behavioural SDRAM with burst length 2
   always @(posedge sdram_clk_0) begin : sdram_model
      logic [3:0] cmd;
      int         key;
      cmd = {cs_n_o, ras_o, cas_o, we_o};
      if (!wb_rst && !cke_o) begin
         $display("ERROR cke_o expected 1 actual %h", cke_o);
         errors++;
      end
      // Write data is due with WRITE and in the cycle after
      if ((wr_lo_pend || cmd == sdr_ctrl_pkg::WRITE) && !dq_oe_o) begin
         $display("ERROR dq_oe_o expected 1 actual %h", dq_oe_o);
         errors++;
      end
      if (wr_lo_pend) begin
         store_half(wr_key, dq_o, dqm_o);
         wr_lo_pend = 1'b0;
      end
      for (int i = 0; i < 3; i++) begin
         rd_pipe[i] = rd_pipe[i+1];
      end
      rd_pipe[3] = '0;
      key = int'({ba_o, open_row[ba_o], a_o[8:0]});
      if (cmd == sdr_ctrl_pkg::READ || cmd == sdr_ctrl_pkg::WRITE) begin
         if (!bank_open[ba_o]) begin
            $display("column command to bank %0d with no open row", ba_o);
            errors++;
         end
      end
      case (cmd)
         sdr_ctrl_pkg::ACTIVE: begin
            if (bank_open[ba_o]) begin
               $display("ACTIVE to bank %0d while a row is still open", ba_o);
               errors++;
            end
            open_row[ba_o]  = a_o;
            bank_open[ba_o] = 1'b1;
         end
         sdr_ctrl_pkg::WRITE: begin
            store_half(key, dq_o, dqm_o);
            wr_key     = key + 1;
            wr_lo_pend = 1'b1;
         end
         sdr_ctrl_pkg::READ: begin
            rd_pipe[`SDR_CL-1] = read_half(key);
            rd_pipe[`SDR_CL]   = read_half(key + 1);
         end
         sdr_ctrl_pkg::PRECHARGE: begin
            if (a_o[10]) begin
               bank_open = 4'b0;
            end else begin
               bank_open[ba_o] = 1'b0;
            end
         end
         sdr_ctrl_pkg::REFRESH: begin
            if (bank_open != 4'b0) begin
               $display("REFRESH while rows are open in banks %b", bank_open);
               errors++;
            end
         end
         default: begin
         end
      endcase
      // Auto-precharge closes the row
      if ((cmd == sdr_ctrl_pkg::READ || cmd == sdr_ctrl_pkg::WRITE) && a_o[10]) begin
         bank_open[ba_o] = 1'b0;
      end
      if (init_n < 4 && cmd != sdr_ctrl_pkg::NOP && cmd != sdr_ctrl_pkg::INHIBIT) begin
         init_cmd[init_n] = cmd;
         init_a[init_n]   = a_o;
         init_n++;
      end
      #2 dq_i = rd_pipe[0];
   end

   task automatic store_half(input int key, input logic [15:0] d, input logic [1:0] m);
      logic [15:0] old;
      old = sdram_mem.exists(key) ? sdram_mem[key] : 16'h0;
      if (!m[1]) old[15:8] = d[15:8];
      if (!m[0]) old[7:0] = d[7:0];
      sdram_mem[key] = old;
   endtask

   function automatic logic [15:0] read_half(input int key);
      return sdram_mem.exists(key) ? sdram_mem[key] : 16'h0;
   endfunction

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic do_beat(input logic we, input logic [22:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, input logic [2:0] cti, input logic [1:0] bte,
                          output logic [31:0] rdat);
      int waited;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      wb_cti_i = cti;
      wb_bte_i = bte;
      waited   = 0;
      @(posedge sdram_clk_0);
      while (!wb_ack_o && waited < BEAT_WORST) begin
         waited++;
         @(posedge sdram_clk_0);
      end
      if (!wb_ack_o) begin
         $display("no ack within %0d cycles at address %h", BEAT_WORST, adr);
         errors++;
      end
      rdat = wb_dat_o;
      #2;
   endtask

   task automatic end_cycle();
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      @(posedge sdram_clk_0);
      #2;
   endtask

   task automatic write_beat(input logic [22:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, input logic [2:0] cti,
                             input logic [1:0] bte);
      logic [31:0] old;
      logic [31:0] unused;
      old = exp_mem.exists(int'(adr)) ? exp_mem[int'(adr)] : 32'h0;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) old[8*b +: 8] = dat[8*b +: 8];
      end
      exp_mem[int'(adr)] = old;
      do_beat(1'b1, adr, dat, sel, cti, bte, unused);
   endtask

   task automatic check_read(input logic [22:0] adr, input logic [2:0] cti,
                             input logic [1:0] bte);
      logic [31:0] got;
      logic [31:0] exp;
      exp = exp_mem.exists(int'(adr)) ? exp_mem[int'(adr)] : 32'h0;
      do_beat(1'b0, adr, 32'h0, 4'hf, cti, bte, got);
      if (got !== exp) begin
         $display("ERROR wb_dat_o adr %h expected %h actual %h", adr, exp, got);
         errors++;
      end
   endtask

   task automatic report(input int num, input string name, input int first_err);
      if (errors == first_err) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, errors - first_err);
         bad_tests++;
      end
   endtask

   initial begin : watchdog
      #(WD_CYCLES * 20);
      $display("watchdog expired after %0d cycles", WD_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   initial begin : main
      logic [22:0] adrs [8];
      logic [22:0] base;
      logic [31:0] r;
      logic [31:0] d;
      int          first;
      int          waited;
      wb_rst   = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      wb_we_i  = 1'b0;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_cti_i = 3'b000;
      wb_bte_i = 2'b00;
      repeat (3) @(posedge sdram_clk_0);
      #2 wb_rst = 1'b0;

      first  = errors;
      waited = 0;
      while (init_n < 4 && waited < int'(`SDR_INIT_WAIT) + 100) begin
         waited++;
         @(posedge sdram_clk_0);
      end
      #2;
      if (init_n < 4) begin
         $display("init sequence incomplete, %0d commands seen", init_n);
         errors++;
      end else begin
         if (init_cmd[0] != sdr_ctrl_pkg::PRECHARGE || !init_a[0][10]) begin
            $display("ERROR cmd step 0 expected %h actual %h a %h",
                     sdr_ctrl_pkg::PRECHARGE, init_cmd[0], init_a[0]);
            errors++;
         end
         for (int i = 1; i < 3; i++) begin
            if (init_cmd[i] != sdr_ctrl_pkg::REFRESH) begin
               $display("ERROR cmd step %0d expected %h actual %h", i,
                        sdr_ctrl_pkg::REFRESH, init_cmd[i]);
               errors++;
            end
         end
         if (init_cmd[3] != sdr_ctrl_pkg::LOAD_MODE || init_a[3][6:4] != `SDR_CL) begin
            $display("ERROR cmd step 3 expected %h actual %h a %h",
                     sdr_ctrl_pkg::LOAD_MODE, init_cmd[3], init_a[3]);
            errors++;
         end
      end
      report(1, "init sequence", first);

      first = errors;
      for (int i = 0; i < 8; i++) begin
         r       = take_bits(23);
         adrs[i] = r[22:0];
         d       = take_bits(32);
         write_beat(adrs[i], d, 4'hf, 3'b000, 2'b00);
         end_cycle();
      end
      for (int i = 0; i < 8; i++) begin
         check_read(adrs[i], 3'b000, 2'b00);
         end_cycle();
      end
      report(2, "classic write and read", first);

      first = errors;
      for (int i = 0; i < 4; i++) begin
         d = take_bits(32);
         write_beat(adrs[i], d, 4'hf, 3'b000, 2'b00);
         end_cycle();
         d = take_bits(32);
         r = take_bits(4);
         write_beat(adrs[i], d, r[3:0], 3'b000, 2'b00);
         end_cycle();
         check_read(adrs[i], 3'b000, 2'b00);
         end_cycle();
      end
      report(3, "partial byte select", first);

      first = errors;
      r     = take_bits(23);
      base  = {r[22:8], r[7:4], 4'h0};
      for (int i = 0; i < 4; i++) begin
         d = take_bits(32);
         write_beat(base + 23'(i), d, 4'hf, (i == 3) ? 3'b111 : 3'b010, 2'b00);
      end
      end_cycle();
      for (int i = 0; i < 4; i++) begin
         check_read(base + 23'(i), (i == 3) ? 3'b111 : 3'b010, 2'b00);
      end
      end_cycle();
      r    = take_bits(23);
      base = {r[22:2], 1'b0, 1'b1};
      for (int i = 0; i < 4; i++) begin
         d = take_bits(32);
         write_beat({base[22:2], 2'(base[1:0] + 2'(i))}, d, 4'hf,
                    (i == 3) ? 3'b111 : 3'b010, 2'b01);
      end
      end_cycle();
      for (int i = 0; i < 4; i++) begin
         check_read({base[22:2], 2'(i)}, 3'b000, 2'b00);
         end_cycle();
      end
      report(4, "incrementing bursts", first);

      first = errors;
      repeat (3 * int'(`SDR_REF_INTERVAL)) @(posedge sdram_clk_0);
      #2;
      for (int i = 0; i < 8; i++) begin
         check_read(adrs[i], 3'b000, 2'b00);
         end_cycle();
      end
      r    = take_bits(23);
      base = {r[22:8], r[7:4], 4'h0};
      for (int i = 0; i < 4; i++) begin
         d = take_bits(32);
         write_beat(base + 23'(i), d, 4'hf, (i == 3) ? 3'b111 : 3'b010, 2'b00);
         // Row stays open across the gap until a refresh closes it
         if (i == 0) begin
            wb_stb_i = 1'b0;
            repeat (int'(`SDR_REF_INTERVAL) + 20) @(posedge sdram_clk_0);
            #2;
         end
      end
      end_cycle();
      for (int i = 0; i < 4; i++) begin
         check_read(base + 23'(i), 3'b000, 2'b00);
         end_cycle();
      end
      report(5, "refresh across idle gaps", first);

      errors = errors + sdr_ctrl_top_inst.sdr_ctrl_sva_inst.fail_cnt;
      $display("tests 5, bad tests %0d, errors %0d, assertion failures %0d", bad_tests,
               errors, sdr_ctrl_top_inst.sdr_ctrl_sva_inst.fail_cnt);
      if (errors == 0 && bad_tests == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+hdl
hdl/sdr_ctrl_pkg.sv
hdl/sdr_req_if.sv
hdl/sdr_wb_port.sv
hdl/sdr_burst_adr.sv
hdl/sdr_cmd_fsm.sv
hdl/sdr_dq_path.sv
hdl/sdr_ctrl_top.sv
verif/sdr_ctrl_sva.sv
verif/sdr_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := sdr_ctrl_tb
FILELIST  := files.f
FLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR   := obj_dir
LOG       := run.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	cat $(LOG)
	@! grep -q '\*\* FAIL \*\*' $(LOG)
	@grep -q '\*\* PASS \*\*' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
